/* hdl/cpu_bus_pkg.sv */
package cpu_bus_pkg;

  // one request as the core presents it
  typedef struct packed {
    logic [19:0] adr;
    logic [15:0] wdat;
    logic        byte_op;
    logic        we;
    logic        m_io;
    logic        memop;
  } cpu_req_t;

  typedef struct packed {
    logic [7:0] hi;
    logic [7:0] lo;
  } byte_pair_t;

  // a bus word seen either whole or as two byte lanes
  typedef union packed {
    logic [15:0] word;
    byte_pair_t  bytes;
  } bus_word_u;

  typedef struct packed {
    logic        active;
    logic        odd_word;
    logic        a0;
    logic [18:0] adr_first;
    logic [18:0] adr_second;
    logic [1:0]  sel_first;
    bus_word_u   wdat;
    logic        we;
    logic        tga;
    logic        byte_op;
  } bus_plan_t;

  typedef struct packed {
    logic [18:0] adr;
    bus_word_u   dat;
    logic [1:0]  sel;
    logic        we;
    logic        tga;
    logic        stb;
    logic        cyc;
  } wb_bus_t;

  typedef enum logic [1:0] {
    idle,
    first_done,
    second,
    second_done
  } bus_state_t;

endpackage

/* hdl/cpu_req_decode.sv */
`timescale 1ns/10ps

module cpu_req_decode (
  input  cpu_bus_pkg::cpu_req_t  req_i,
  output cpu_bus_pkg::bus_plan_t plan_o
);

  logic        a0;
  logic        odd_word;
  logic [18:0] word_adr;

  assign a0       = req_i.adr[0];
  assign odd_word = a0 & ~req_i.byte_op;
  assign word_adr = req_i.adr[19:1];

  // ==============================
  // strobes and addressing
  // ==============================

  assign plan_o.active     = req_i.memop | req_i.m_io;
  assign plan_o.odd_word   = odd_word;
  assign plan_o.a0         = a0;
  assign plan_o.adr_first  = word_adr;
  // only used when a word straddles two bus words
  assign plan_o.adr_second = word_adr + 19'd1;

  // odd address lands in the high lane, even byte in the low lane
  always_comb
  begin
    if (a0)
    begin
      plan_o.sel_first = 2'b10;
    end
    else if (req_i.byte_op)
    begin
      plan_o.sel_first = 2'b01;
    end
    else
    begin
      plan_o.sel_first = 2'b11;
    end
  end

  // ==============================
  // write data lanes
  // ==============================

  // at an odd address the low byte goes out first on the high lane
  always_comb
  begin
    if (a0)
    begin
      plan_o.wdat.bytes.hi = req_i.wdat[7:0];
      plan_o.wdat.bytes.lo = req_i.wdat[15:8];
    end
    else
    begin
      plan_o.wdat.word = req_i.wdat;
    end
  end

  assign plan_o.we      = req_i.we;
  assign plan_o.tga     = req_i.m_io;
  assign plan_o.byte_op = req_i.byte_op;

endmodule

/* hdl/wb_master.sv */
`timescale 1ns/10ps

module wb_master (
  input  logic                   wb_clk_i,
  input  logic                   wb_rst_i,
  input  cpu_bus_pkg::bus_plan_t plan_i,
  input  logic                   wb_ack_i,
  output cpu_bus_pkg::wb_bus_t   bus_o,
  output cpu_bus_pkg::bus_state_t state_o,
  output logic                   cpu_block_o
);

  import cpu_bus_pkg::*;

  // ==============================
  // bus outputs per state
  // ==============================

  always_comb
  begin
    bus_o.dat = plan_i.wdat;
    bus_o.we  = plan_i.we;
    bus_o.tga = plan_i.tga;
    case (state_o)
      first_done:
      begin
        // stb is down and cyc stays up only while a second cycle follows
        bus_o.adr   = plan_i.adr_first;
        bus_o.sel   = plan_i.sel_first;
        bus_o.stb   = 1'b0;
        bus_o.cyc   = plan_i.odd_word;
        cpu_block_o = plan_i.odd_word | wb_ack_i;
      end
      second:
      begin
        bus_o.adr   = plan_i.adr_second;
        bus_o.sel   = 2'b01;
        bus_o.stb   = 1'b1;
        bus_o.cyc   = 1'b1;
        cpu_block_o = 1'b1;
      end
      second_done:
      begin
        bus_o.adr   = plan_i.adr_second;
        bus_o.sel   = 2'b01;
        bus_o.stb   = 1'b0;
        bus_o.cyc   = 1'b0;
        cpu_block_o = wb_ack_i;
      end
      default:
      begin
        // a held request starts the first cycle right away
        bus_o.adr   = plan_i.adr_first;
        bus_o.sel   = plan_i.sel_first;
        bus_o.stb   = plan_i.active;
        bus_o.cyc   = plan_i.active;
        cpu_block_o = plan_i.active;
      end
    endcase
  end

  // ==============================
  // sequencer
  // ==============================

  always_ff @(posedge wb_clk_i)
  begin
    if (wb_rst_i)
    begin
      state_o <= idle;
    end
    else
    begin
      case (state_o)
        idle:
        begin
          if (wb_ack_i && plan_i.active)
          begin
            state_o <= first_done;
          end
        end
        first_done:
        begin
          // wait for the slave to drop ack before moving on
          if (!wb_ack_i)
          begin
            state_o <= plan_i.odd_word ? second : idle;
          end
        end
        second:
        begin
          if (wb_ack_i)
          begin
            state_o <= second_done;
          end
        end
        default:
        begin
          if (!wb_ack_i)
          begin
            state_o <= idle;
          end
        end
      endcase
    end
  end

endmodule

/* hdl/read_assembler.sv */
`timescale 1ns/10ps

module read_assembler (
  input  logic                    wb_clk_i,
  input  logic                    wb_rst_i,
  input  cpu_bus_pkg::bus_state_t state_i,
  input  logic                    wb_ack_i,
  input  cpu_bus_pkg::bus_plan_t  plan_i,
  input  cpu_bus_pkg::bus_word_u  rdat_i,
  output cpu_bus_pkg::bus_word_u  cpu_dat_o
);

  import cpu_bus_pkg::*;

  bus_word_u hi_ext;
  bus_word_u lo_ext;

  // sign-extended views of the two lanes
  assign hi_ext.word = {{8{rdat_i.bytes.hi[7]}}, rdat_i.bytes.hi};
  assign lo_ext.word = {{8{rdat_i.bytes.lo[7]}}, rdat_i.bytes.lo};

  always_ff @(posedge wb_clk_i)
  begin
    if (wb_rst_i)
    begin
      cpu_dat_o.word <= 16'h0000;
    end
    else if (state_i == idle && wb_ack_i)
    begin
      if (plan_i.a0)
      begin
        cpu_dat_o <= hi_ext;
      end
      else if (plan_i.byte_op)
      begin
        cpu_dat_o <= lo_ext;
      end
      else
      begin
        cpu_dat_o <= rdat_i;
      end
    end
    else if (state_i == second && wb_ack_i)
    begin
      // upper half of a split word comes from the next word's low lane
      cpu_dat_o.bytes.hi <= rdat_i.bytes.lo;
    end
  end

endmodule

/* hdl/wb_sram_slave.sv */
`timescale 1ns/10ps

module wb_sram_slave #(
  parameter int WAIT_STATES = 1,
  parameter int MEM_WORDS   = 1024
) (
  input  logic                   wb_clk_i,
  input  logic                   wb_rst_i,
  input  cpu_bus_pkg::wb_bus_t   bus_i,
  output logic                   wb_ack_o,
  output cpu_bus_pkg::bus_word_u rdat_o
);

  import cpu_bus_pkg::*;

  localparam int AW = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

  bus_word_u mem [MEM_WORDS];
  bus_word_u io_regs [16];

  logic [2:0]    wait_cnt;
  logic          req;
  logic          ack_now;
  logic [AW-1:0] mem_idx;
  logic [3:0]    io_idx;

  assign req     = bus_i.stb & bus_i.cyc;
  assign ack_now = req & ~wb_ack_o & (wait_cnt == 3'(WAIT_STATES));
  assign mem_idx = AW'(bus_i.adr % MEM_WORDS);
  assign io_idx  = bus_i.adr[3:0];

  // ==============================
  // wait states and ack
  // ==============================

  // ack stays up until the master takes stb away
  always_ff @(posedge wb_clk_i)
  begin
    if (wb_rst_i || !req)
    begin
      wait_cnt <= 3'd0;
      wb_ack_o <= 1'b0;
    end
    else if (ack_now)
    begin
      wb_ack_o <= 1'b1;
    end
    else if (!wb_ack_o)
    begin
      wait_cnt <= wait_cnt + 3'd1;
    end
  end

  // ==============================
  // storage
  // ==============================

  always_ff @(posedge wb_clk_i)
  begin
    if (ack_now)
    begin
      rdat_o <= bus_i.tga ? io_regs[io_idx] : mem[mem_idx];
      if (bus_i.we && bus_i.tga)
      begin
        if (bus_i.sel[1])
          io_regs[io_idx].bytes.hi <= bus_i.dat.bytes.hi;
        if (bus_i.sel[0])
          io_regs[io_idx].bytes.lo <= bus_i.dat.bytes.lo;
      end
      else if (bus_i.we)
      begin
        if (bus_i.sel[1])
          mem[mem_idx].bytes.hi <= bus_i.dat.bytes.hi;
        if (bus_i.sel[0])
          mem[mem_idx].bytes.lo <= bus_i.dat.bytes.lo;
      end
    end
  end

endmodule

/* hdl/cpu_wb_top.sv */
`timescale 1ns/10ps

module cpu_wb_top #(
  parameter int WAIT_STATES = 1,
  parameter int MEM_WORDS   = 1024
) (
  input  logic        wb_clk_i,
  input  logic        wb_rst_i,
  input  logic [19:0] cpu_adr_i,
  input  logic [15:0] cpu_dat_i,
  input  logic        cpu_byte_i,
  input  logic        cpu_we_i,
  input  logic        cpu_m_io_i,
  input  logic        cpu_memop_i,
  output logic        cpu_block_o,
  output logic [15:0] cpu_dat_o
);

  import cpu_bus_pkg::*;

  cpu_req_t   req;
  bus_plan_t  plan;
  wb_bus_t    bus;
  bus_state_t state;
  bus_word_u  rdat;
  bus_word_u  asm_dat;
  logic       wb_ack;

  assign req.adr     = cpu_adr_i;
  assign req.wdat    = cpu_dat_i;
  assign req.byte_op = cpu_byte_i;
  assign req.we      = cpu_we_i;
  assign req.m_io    = cpu_m_io_i;
  assign req.memop   = cpu_memop_i;

  assign cpu_dat_o = asm_dat.word;

  cpu_req_decode decode_i (
    .req_i  (req),
    .plan_o (plan)
  );

  wb_master master_i (
    .wb_clk_i    (wb_clk_i),
    .wb_rst_i    (wb_rst_i),
    .plan_i      (plan),
    .wb_ack_i    (wb_ack),
    .bus_o       (bus),
    .state_o     (state),
    .cpu_block_o (cpu_block_o)
  );

  read_assembler assembler_i (
    .wb_clk_i  (wb_clk_i),
    .wb_rst_i  (wb_rst_i),
    .state_i   (state),
    .wb_ack_i  (wb_ack),
    .plan_i    (plan),
    .rdat_i    (rdat),
    .cpu_dat_o (asm_dat)
  );

  wb_sram_slave #(
    .WAIT_STATES (WAIT_STATES),
    .MEM_WORDS   (MEM_WORDS)
  ) slave_i (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .bus_i    (bus),
    .wb_ack_o (wb_ack),
    .rdat_o   (rdat)
  );

endmodule

/* testbench/tb_cpu_wb.sv */
`timescale 1ns/10ps

module tb_cpu_wb;

  import cpu_bus_pkg::*;

  localparam int WAIT_STATES = 2;
  localparam int MAX_TESTS   = 64;
  // worst case is a split word plus the drive, drop and idle check cycles
  localparam int CYCLES_PER_TEST = 2 * (WAIT_STATES + 2) + 10;

  logic        wb_clk_i;
  logic        wb_rst_i;
  logic [19:0] cpu_adr_i;
  logic [15:0] cpu_dat_i;
  logic        cpu_byte_i;
  logic        cpu_we_i;
  logic        cpu_m_io_i;
  logic        cpu_memop_i;
  logic        cpu_block_o;
  logic [15:0] cpu_dat_o;

  // one entry per access line of the data file
  logic [8*24-1:0] t_name [MAX_TESTS];
  logic [8*8-1:0]  t_kind [MAX_TESTS];
  logic [8*8-1:0]  t_space [MAX_TESTS];
  logic [8*8-1:0]  t_size [MAX_TESTS];
  logic [19:0]     t_adr [MAX_TESTS];
  logic [15:0]     t_wdat [MAX_TESTS];
  logic [15:0]     t_exp [MAX_TESTS];
  int              n_tests;
  logic            run_started;

  cpu_wb_top #(
    .WAIT_STATES (WAIT_STATES),
    .MEM_WORDS   (1024)
  ) dut_i (
    .wb_clk_i    (wb_clk_i),
    .wb_rst_i    (wb_rst_i),
    .cpu_adr_i   (cpu_adr_i),
    .cpu_dat_i   (cpu_dat_i),
    .cpu_byte_i  (cpu_byte_i),
    .cpu_we_i    (cpu_we_i),
    .cpu_m_io_i  (cpu_m_io_i),
    .cpu_memop_i (cpu_memop_i),
    .cpu_block_o (cpu_block_o),
    .cpu_dat_o   (cpu_dat_o)
  );

  always #10 wb_clk_i = ~wb_clk_i;

  // ==============================
  // checks
  // ==============================

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_word(input logic [8*24-1:0] name, input bus_word_u expected,
                            input bus_word_u actual);
    if (actual !== expected)
      abort_run($sformatf("Mismatch in %0s: expected %h, actual %h",
                          name, expected.word, actual.word));
  endtask

  task automatic check_block_idle(input logic [8*24-1:0] name, input logic actual);
    if (actual !== 1'b0)
      abort_run($sformatf("Mismatch in %0s: expected block 0, actual %b", name, actual));
  endtask

  // ==============================
  // stimulus
  // ==============================

  task automatic load_tests();
    int              fd;
    int              code;
    logic [8*24-1:0] name;
    logic [8*8-1:0]  kind;
    logic [8*8-1:0]  space;
    logic [8*8-1:0]  size;
    logic [19:0]     adr;
    logic [15:0]     wdat;
    logic [15:0]     expect_word;
    logic [8*120-1:0] rest;
    fd = $fopen("testbench/cpu_wb_testdata.txt", "r");
    if (fd == 0)
      abort_run("could not open the test data file testbench/cpu_wb_testdata.txt");
    n_tests = 0;
    while (!$feof(fd) && n_tests < MAX_TESTS)
    begin
      code = $fscanf(fd, "%s", name);
      if (code == 1 && name == "#")
      begin
        code = $fgets(rest, fd);
      end
      else if (code == 1)
      begin
        code = $fscanf(fd, "%s %s %s %h %h %h", kind, space, size, adr, wdat, expect_word);
        if (code != 6 || !(kind == "read" || kind == "write")
            || !(space == "mem" || space == "io") || !(size == "byte" || size == "word"))
          abort_run($sformatf("test data line %0s could not be understood", name));
        t_name[n_tests]  = name;
        t_kind[n_tests]  = kind;
        t_space[n_tests] = space;
        t_size[n_tests]  = size;
        t_adr[n_tests]   = adr;
        t_wdat[n_tests]  = wdat;
        t_exp[n_tests]   = expect_word;
        n_tests++;
      end
    end
    $fclose(fd);
    if (n_tests == 0)
      abort_run("the test data file holds no accesses");
  endtask

  // the core holds its request until it sees block low, then drops the strobe
  task automatic run_access(input int idx);
    @(negedge wb_clk_i);
    cpu_adr_i   = t_adr[idx];
    cpu_dat_i   = t_wdat[idx];
    cpu_byte_i  = (t_size[idx] == "byte");
    cpu_we_i    = (t_kind[idx] == "write");
    cpu_m_io_i  = (t_space[idx] == "io");
    cpu_memop_i = (t_space[idx] == "mem");
    do
      @(negedge wb_clk_i);
    while (cpu_block_o !== 1'b0);
    if (t_kind[idx] == "read")
      check_word(t_name[idx], t_exp[idx], cpu_dat_o);
    cpu_memop_i = 1'b0;
    cpu_m_io_i  = 1'b0;
    @(negedge wb_clk_i);
    check_block_idle(t_name[idx], cpu_block_o);
  endtask

  initial
  begin
    wb_clk_i    = 1'b0;
    wb_rst_i    = 1'b1;
    cpu_adr_i   = 20'h00000;
    cpu_dat_i   = 16'h0000;
    cpu_byte_i  = 1'b0;
    cpu_we_i    = 1'b0;
    cpu_m_io_i  = 1'b0;
    cpu_memop_i = 1'b0;
    run_started = 1'b0;
    load_tests();
    repeat (10) @(negedge wb_clk_i);
    wb_rst_i    = 1'b0;
    run_started = 1'b1;
    check_word("after_reset", 16'h0000, cpu_dat_o);
    for (int i = 0; i < n_tests; i++)
      run_access(i);
    $display("Simulation passed");
    $finish;
  end

  // bounded by the worst case access time of every line in the file
  initial
  begin
    wait (run_started === 1'b1);
    repeat (n_tests * CYCLES_PER_TEST) @(posedge wb_clk_i);
    abort_run("watchdog expired because the bus never completed an access");
  end

endmodule

/* testbench/cpu_wb_testdata.txt */
# columns: name kind(read/write) space(mem/io) size(byte/word) byte_adr(hex)
# then write_data(hex) and expected_read_word(hex), unused fields are 0000
w_al_word     write mem word 00010 a5c3 0000
r_al_word     read  mem word 00010 0000 a5c3
w_byte_src    write mem word 00020 8af1 0000
r_byte_even   read  mem byte 00020 0000 fff1
r_byte_odd    read  mem byte 00021 0000 ff8a
w_byte_pos    write mem word 00030 3c7f 0000
r_byte_pos_e  read  mem byte 00030 0000 007f
r_byte_pos_o  read  mem byte 00031 0000 003c
w_pre_lo      write mem word 00040 1111 0000
w_pre_hi      write mem word 00042 2222 0000
w_odd_word    write mem word 00041 beef 0000
r_odd_word    read  mem word 00041 0000 beef
r_odd_lower   read  mem word 00040 0000 ef11
r_odd_upper   read  mem word 00042 0000 22be
w_lane_base   write mem word 00050 1234 0000
w_lane_lo     write mem byte 00050 00ab 0000
r_lane_lo     read  mem word 00050 0000 12ab
w_lane_hi     write mem byte 00051 00cd 0000
r_lane_hi     read  mem word 00050 0000 cdab
w_io_mem      write mem word 00006 5a5a 0000
w_io_reg      write io  word 00006 c3c3 0000
r_io_mem      read  mem word 00006 0000 5a5a
r_io_reg      read  io  word 00006 0000 c3c3
r_io_byte     read  io  byte 00007 0000 ffc3

/* tb.f */
hdl/cpu_bus_pkg.sv
hdl/cpu_req_decode.sv
hdl/wb_master.sv
hdl/read_assembler.sv
hdl/wb_sram_slave.sv
hdl/cpu_wb_top.sv
testbench/tb_cpu_wb.sv
